// ==== burst_split_params.svh ====
`ifndef BURST_SPLIT_PARAMS_SVH
`define BURST_SPLIT_PARAMS_SVH

// ----------------------------------------
// Bus geometry
// ----------------------------------------
// Byte address width
`define BS_ADDR_W 32
// Data width, a multiple of 8
`define BS_DATA_W 32
// Width of the AXI ID fields
`define BS_ID_W 4

// ----------------------------------------
// Buffering
// ----------------------------------------
// Upstream write bursts that may wait for B at once
`define BS_MAX_TXNS 4

`endif

// ==== axi_chan_pkg.sv ====
`default_nettype none

`include "burst_split_params.svh"

package axi_chan_pkg;

  // ----------------------------------------
  // Field types
  // ----------------------------------------
  typedef logic [`BS_ADDR_W-1:0]   addr_t;
  // Beats minus one
  typedef logic [7:0]              len_t;
  // Log2 of the bytes in one beat
  typedef logic [2:0]              size_t;
  typedef logic [`BS_ID_W-1:0]     id_t;
  typedef logic [`BS_DATA_W-1:0]   data_t;
  typedef logic [`BS_DATA_W/8-1:0] strb_t;
  typedef logic [1:0]              resp_t;

  // Response codes in use here
  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_SLVERR = 2'b10;

  // ----------------------------------------
  // Channel payloads
  // ----------------------------------------
  // Write address, burst type is always INCR
  typedef struct packed {
    id_t   id;
    addr_t addr;
    len_t  len;
    size_t size;
  } aw_chan_t;

  // Write data beat
  typedef struct packed {
    data_t data;
    strb_t strb;
    logic  last;
  } w_chan_t;

  // Write response
  typedef struct packed {
    id_t   id;
    resp_t resp;
  } b_chan_t;

endpackage

`default_nettype wire

// ==== split_ctrl_pkg.sv ====
`default_nettype none

package split_ctrl_pkg;

  // Beats still to be issued, up to 256
  typedef logic [8:0] num_beats_t;
  // Sub-bursts in one upstream burst, up to 256
  typedef logic [8:0] sub_cnt_t;

  // Handed from the AW side to the B side per upstream burst
  typedef struct packed {
    sub_cnt_t          sub_cnt;
    axi_chan_pkg::id_t id;
  } split_info_t;

  // AW issue FSM
  typedef enum logic {
    AX_IDLE,
    AX_BUSY
  } ax_state_e;

  // B merge FSM
  typedef enum logic {
    B_COLLECT,
    B_HOLD
  } b_state_e;

endpackage

`default_nettype wire

// ==== aw_splitter.sv ====
`timescale 1ns/1ns
`default_nettype none

module aw_splitter (
  input  wire logic                        clk_i,
  input  wire logic                        rst_i,
  input  wire axi_chan_pkg::len_t          len_limit_i,
  input  wire axi_chan_pkg::aw_chan_t      aw_i,
  input  wire logic                        aw_valid_i,
  output logic                             aw_ready_o,
  output axi_chan_pkg::aw_chan_t           aw_o,
  output logic                             aw_valid_o,
  input  wire logic                        aw_ready_i,
  output split_ctrl_pkg::split_info_t      info_o,
  output logic                             info_push_o,
  input  wire logic                        info_full_i
);

  split_ctrl_pkg::ax_state_e  state_d, state_q;
  axi_chan_pkg::aw_chan_t     ax_d, ax_q;
  // Beats left to issue including the sub-burst on offer
  split_ctrl_pkg::num_beats_t num_beats_d, num_beats_q;
  // Largest sub-burst in beats
  split_ctrl_pkg::num_beats_t max_beats;
  // Beats in the incoming burst
  split_ctrl_pkg::num_beats_t in_beats;
  logic                       needs_split;
  logic                       last_sub;

  assign max_beats   = {1'b0, len_limit_i} + 9'd1;
  assign in_beats    = {1'b0, aw_i.len} + 9'd1;
  assign needs_split = aw_i.len > len_limit_i;
  assign last_sub    = num_beats_q <= max_beats;

  // Sub-burst count as ceil(beats / max_beats) taken at acceptance
  assign info_o.sub_cnt = split_ctrl_pkg::sub_cnt_t'((in_beats + {1'b0, len_limit_i}) / max_beats);
  assign info_o.id      = aw_i.id;

  // ----------------------------------------
  // Issue FSM
  // ----------------------------------------
  always_comb begin
    state_d     = state_q;
    ax_d        = ax_q;
    num_beats_d = num_beats_q;
    aw_o        = ax_q;
    aw_valid_o  = 1'b0;
    aw_ready_o  = 1'b0;
    info_push_o = 1'b0;
    unique case (state_q)
      split_ctrl_pkg::AX_IDLE: begin
        aw_o = aw_i;
        // No new burst while the B side has no room for its info
        if (aw_valid_i && !info_full_i) begin
          if (!needs_split) begin
            // Short burst goes straight through
            aw_valid_o  = 1'b1;
            aw_ready_o  = aw_ready_i;
            info_push_o = aw_ready_i;
          end else begin
            // Take it now and offer the first sub-burst in the same cycle
            aw_o.len    = len_limit_i;
            aw_valid_o  = 1'b1;
            aw_ready_o  = 1'b1;
            info_push_o = 1'b1;
            ax_d        = aw_i;
            num_beats_d = in_beats;
            if (aw_ready_i) begin
              ax_d.addr   = aw_i.addr + (axi_chan_pkg::addr_t'(max_beats) << aw_i.size);
              num_beats_d = in_beats - max_beats;
            end
            state_d = split_ctrl_pkg::AX_BUSY;
          end
        end
      end
      split_ctrl_pkg::AX_BUSY: begin
        aw_valid_o = 1'b1;
        // Remainder is whatever is left and the others are full size
        if (last_sub) begin
          aw_o.len = axi_chan_pkg::len_t'(num_beats_q - 9'd1);
        end else begin
          aw_o.len = len_limit_i;
        end
        if (aw_ready_i) begin
          if (last_sub) begin
            state_d = split_ctrl_pkg::AX_IDLE;
          end else begin
            ax_d.addr   = ax_q.addr + (axi_chan_pkg::addr_t'(max_beats) << ax_q.size);
            num_beats_d = num_beats_q - max_beats;
          end
        end
      end
      default: state_d = split_ctrl_pkg::AX_IDLE;
    endcase
  end

  // ----------------------------------------
  // Registers
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q     <= split_ctrl_pkg::AX_IDLE;
      num_beats_q <= '0;
    end else begin
      state_q     <= state_d;
      num_beats_q <= num_beats_d;
    end
  end

  // Address and attributes of the burst being split
  always_ff @(posedge clk_i) begin
    ax_q <= ax_d;
  end

  // Nothing downstream may exceed the limit
  assert property (@(posedge clk_i) disable iff (rst_i)
    aw_valid_o |-> aw_o.len <= len_limit_i)
    else $error("AW sub-burst longer than the length limit");

endmodule

`default_nettype wire

// ==== w_last_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module w_last_gen (
  input  wire logic                   clk_i,
  input  wire logic                   rst_i,
  input  wire axi_chan_pkg::len_t     len_limit_i,
  input  wire axi_chan_pkg::w_chan_t  w_i,
  input  wire logic                   w_valid_i,
  output logic                        w_ready_o,
  output axi_chan_pkg::w_chan_t       w_o,
  output logic                        w_valid_o,
  input  wire logic                   w_ready_i
);

  // Beats already passed in the current sub-burst
  axi_chan_pkg::len_t beat_cnt_q;
  logic               w_hs;
  logic               sub_end;
  // Previous transferred beat carried last downstream
  logic               prev_last_q;

  // ----------------------------------------
  // Pass-through with new last
  // ----------------------------------------
  assign w_hs    = w_valid_i && w_ready_i;
  // Sub-burst ends at the limit or at the end of the upstream burst
  assign sub_end = (beat_cnt_q == len_limit_i) || w_i.last;

  always_comb begin
    w_o      = w_i;
    w_o.last = sub_end;
  end

  assign w_valid_o = w_valid_i;
  assign w_ready_o = w_ready_i;

  // ----------------------------------------
  // Beat counter
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      beat_cnt_q  <= '0;
      prev_last_q <= 1'b0;
    end else if (w_hs) begin
      prev_last_q <= sub_end;
      if (sub_end) begin
        beat_cnt_q <= '0;
      end else begin
        beat_cnt_q <= beat_cnt_q + 8'd1;
      end
    end
  end

  // Counter-made last needs beats in between when the limit is not zero
  assert property (@(posedge clk_i) disable iff (rst_i)
    (w_hs && prev_last_q && !w_i.last && len_limit_i != '0) |-> !w_o.last)
    else $error("W last on two beats in a row without upstream last");

endmodule

`default_nettype wire

// ==== b_merger.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "burst_split_params.svh"

module b_merger (
  input  wire logic                         clk_i,
  input  wire logic                         rst_i,
  input  wire split_ctrl_pkg::split_info_t  info_i,
  input  wire logic                         info_push_i,
  output logic                              info_full_o,
  input  wire axi_chan_pkg::b_chan_t        b_i,
  input  wire logic                         b_valid_i,
  output logic                              b_ready_o,
  output axi_chan_pkg::b_chan_t             b_o,
  output logic                              b_valid_o,
  input  wire logic                         b_ready_i
);

  localparam int PTR_W = (`BS_MAX_TXNS > 1) ? $clog2(`BS_MAX_TXNS) : 1;

  typedef logic [PTR_W-1:0] ptr_t;
  typedef logic [PTR_W:0]   fill_t;

  // ----------------------------------------
  // Split info FIFO
  // ----------------------------------------
  split_ctrl_pkg::split_info_t info_mem [`BS_MAX_TXNS];
  ptr_t                        wr_ptr_q, rd_ptr_q;
  fill_t                       fill_q;
  split_ctrl_pkg::split_info_t head;
  logic                        empty;
  logic                        pop;

  assign head        = info_mem[rd_ptr_q];
  assign empty       = fill_q == '0;
  assign info_full_o = fill_q == fill_t'(`BS_MAX_TXNS);

  always_ff @(posedge clk_i) begin
    if (info_push_i) begin
      info_mem[wr_ptr_q] <= info_i;
    end
  end

  // Pointers wrap at the depth so it need not be a power of two
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      fill_q   <= '0;
    end else begin
      if (info_push_i) begin
        wr_ptr_q <= (wr_ptr_q == ptr_t'(`BS_MAX_TXNS - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == ptr_t'(`BS_MAX_TXNS - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      fill_q <= fill_q + fill_t'(info_push_i) - fill_t'(pop);
    end
  end

  // ----------------------------------------
  // Merge FSM
  // ----------------------------------------
  split_ctrl_pkg::b_state_e state_d, state_q;
  // Responses already absorbed for the head burst
  split_ctrl_pkg::sub_cnt_t rcv_cnt_d, rcv_cnt_q;
  logic                     err_d, err_q;
  logic                     is_final;
  logic                     b_err;

  assign is_final = (rcv_cnt_q + 9'd1) == head.sub_cnt;
  assign b_err    = b_i.resp == axi_chan_pkg::RESP_SLVERR;

  // Merged response from the head info and the waiting downstream B
  assign b_o.id   = head.id;
  assign b_o.resp = (err_q || b_err) ? axi_chan_pkg::RESP_SLVERR : axi_chan_pkg::RESP_OKAY;

  always_comb begin
    state_d   = state_q;
    rcv_cnt_d = rcv_cnt_q;
    err_d     = err_q;
    b_ready_o = 1'b0;
    b_valid_o = 1'b0;
    pop       = 1'b0;
    unique case (state_q)
      split_ctrl_pkg::B_COLLECT: begin
        if (b_valid_i && !empty) begin
          if (!is_final) begin
            // Swallow intermediate response and remember any error
            b_ready_o = 1'b1;
            rcv_cnt_d = rcv_cnt_q + 9'd1;
            err_d     = err_q || b_err;
          end else begin
            b_valid_o = 1'b1;
            if (b_ready_i) begin
              b_ready_o = 1'b1;
              pop       = 1'b1;
              rcv_cnt_d = '0;
              err_d     = 1'b0;
            end else begin
              state_d = split_ctrl_pkg::B_HOLD;
            end
          end
        end
      end
      split_ctrl_pkg::B_HOLD: begin
        // Upstream stalled so downstream B is left waiting
        b_valid_o = b_valid_i;
        if (b_valid_i && b_ready_i) begin
          b_ready_o = 1'b1;
          pop       = 1'b1;
          rcv_cnt_d = '0;
          err_d     = 1'b0;
          state_d   = split_ctrl_pkg::B_COLLECT;
        end
      end
      default: state_d = split_ctrl_pkg::B_COLLECT;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q   <= split_ctrl_pkg::B_COLLECT;
      rcv_cnt_q <= '0;
      err_q     <= 1'b0;
    end else begin
      state_q   <= state_d;
      rcv_cnt_q <= rcv_cnt_d;
      err_q     <= err_d;
    end
  end

  // B only for bursts whose AW has been taken
  assert property (@(posedge clk_i) disable iff (rst_i) b_valid_i |-> !empty)
    else $error("Downstream B with no outstanding burst");
  // AW side must respect the full flag
  assert property (@(posedge clk_i) disable iff (rst_i) info_push_i |-> !info_full_o)
    else $error("Split info pushed into a full FIFO");

endmodule

`default_nettype wire

// ==== burst_splitter_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module burst_splitter_top (
  input  wire logic                    clk_i,
  input  wire logic                    rst_i,
  input  wire axi_chan_pkg::len_t      len_limit_i,
  // Upstream side
  input  wire axi_chan_pkg::aw_chan_t  slv_aw_i,
  input  wire logic                    slv_aw_valid_i,
  output logic                         slv_aw_ready_o,
  input  wire axi_chan_pkg::w_chan_t   slv_w_i,
  input  wire logic                    slv_w_valid_i,
  output logic                         slv_w_ready_o,
  output axi_chan_pkg::b_chan_t        slv_b_o,
  output logic                         slv_b_valid_o,
  input  wire logic                    slv_b_ready_i,
  // Downstream side
  output axi_chan_pkg::aw_chan_t       mst_aw_o,
  output logic                         mst_aw_valid_o,
  input  wire logic                    mst_aw_ready_i,
  output axi_chan_pkg::w_chan_t        mst_w_o,
  output logic                         mst_w_valid_o,
  input  wire logic                    mst_w_ready_i,
  input  wire axi_chan_pkg::b_chan_t   mst_b_i,
  input  wire logic                    mst_b_valid_i,
  output logic                         mst_b_ready_o
);

  // Per-burst sub-burst count, AW side to B side
  split_ctrl_pkg::split_info_t info;
  logic                        info_push;
  logic                        info_full;

  // ----------------------------------------
  // AW path
  // ----------------------------------------
  aw_splitter u_aw_splitter (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .len_limit_i (len_limit_i),
    .aw_i        (slv_aw_i),
    .aw_valid_i  (slv_aw_valid_i),
    .aw_ready_o  (slv_aw_ready_o),
    .aw_o        (mst_aw_o),
    .aw_valid_o  (mst_aw_valid_o),
    .aw_ready_i  (mst_aw_ready_i),
    .info_o      (info),
    .info_push_o (info_push),
    .info_full_i (info_full)
  );

  // ----------------------------------------
  // W path
  // ----------------------------------------
  w_last_gen u_w_last_gen (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .len_limit_i (len_limit_i),
    .w_i         (slv_w_i),
    .w_valid_i   (slv_w_valid_i),
    .w_ready_o   (slv_w_ready_o),
    .w_o         (mst_w_o),
    .w_valid_o   (mst_w_valid_o),
    .w_ready_i   (mst_w_ready_i)
  );

  // ----------------------------------------
  // B path
  // ----------------------------------------
  b_merger u_b_merger (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .info_i      (info),
    .info_push_i (info_push),
    .info_full_o (info_full),
    .b_i         (mst_b_i),
    .b_valid_i   (mst_b_valid_i),
    .b_ready_o   (mst_b_ready_o),
    .b_o         (slv_b_o),
    .b_valid_o   (slv_b_valid_o),
    .b_ready_i   (slv_b_ready_i)
  );

endmodule

`default_nettype wire

// ==== tb_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "burst_split_params.svh"

module tb_checker (
  input  wire logic                   clk_i,
  input  wire logic                   rst_i,
  input  wire axi_chan_pkg::len_t     len_limit_i,
  input  wire axi_chan_pkg::aw_chan_t slv_aw_i,
  input  wire logic                   slv_aw_valid_i,
  input  wire logic                   slv_aw_ready_i,
  input  wire axi_chan_pkg::w_chan_t  slv_w_i,
  input  wire logic                   slv_w_valid_i,
  input  wire logic                   slv_w_ready_i,
  input  wire axi_chan_pkg::b_chan_t  slv_b_i,
  input  wire logic                   slv_b_valid_i,
  input  wire logic                   slv_b_ready_i,
  input  wire axi_chan_pkg::aw_chan_t mst_aw_i,
  input  wire logic                   mst_aw_valid_i,
  input  wire logic                   mst_aw_ready_i,
  input  wire axi_chan_pkg::w_chan_t  mst_w_i,
  input  wire logic                   mst_w_valid_i,
  input  wire logic                   mst_w_ready_i,
  input  wire axi_chan_pkg::b_chan_t  mst_b_i,
  input  wire logic                   mst_b_valid_i,
  input  wire logic                   mst_b_ready_i,
  output int                          errors_o,
  output logic                        drained_o
);

  // Running test, written by the testbench top
  string test_name = "none";

  // Expected downstream AW, in issue order
  axi_chan_pkg::aw_chan_t exp_aw_q[$];
  // Beats minus one per expected sub-burst, W order
  axi_chan_pkg::len_t     exp_wlen_q[$];
  // Per upstream burst still collecting downstream B
  int unsigned            grp_cnt_q[$];
  axi_chan_pkg::id_t      grp_id_q[$];
  // Merged responses ready to be matched upstream
  axi_chan_pkg::b_chan_t  exp_b_q[$];
  axi_chan_pkg::aw_chan_t exp_sub;
  axi_chan_pkg::b_chan_t  exp_b;
  int unsigned            beat_cnt;
  int unsigned            grp_rcv;
  logic                   grp_err;
  logic                   exp_last;
  // Upstream bursts accepted and not yet answered
  int                     outstanding;

  // ----------------------------------------
  // Reference model
  // ----------------------------------------
  // Expand one upstream burst into its sub-bursts
  function automatic void expand_burst(input axi_chan_pkg::aw_chan_t up,
                                       input axi_chan_pkg::len_t lim);
    axi_chan_pkg::aw_chan_t sub;
    int unsigned left;
    int unsigned lim_beats;
    int unsigned k;
    left      = 32'(up.len) + 1;
    lim_beats = 32'(lim) + 1;
    k         = 0;
    while (left > 0) begin
      sub      = up;
      // Each piece starts right after the previous one
      sub.addr = up.addr + axi_chan_pkg::addr_t'(k * lim_beats * (32'd1 << up.size));
      sub.len  = (left > lim_beats) ? lim : axi_chan_pkg::len_t'(left - 1);
      exp_aw_q.push_back(sub);
      exp_wlen_q.push_back(sub.len);
      left = (left > lim_beats) ? left - lim_beats : 0;
      k++;
    end
    grp_cnt_q.push_back(k);
    grp_id_q.push_back(up.id);
  endfunction

  task automatic value_error(input string what, input logic [63:0] exp_v,
                             input logic [63:0] act_v);
    $display("CHECK FAILED %s: %s expected %0h actual %0h", test_name, what, exp_v, act_v);
    errors_o++;
  endtask

  task automatic event_error(input string msg);
    $display("Error in test %s: %s", test_name, msg);
    errors_o++;
  endtask

  // ----------------------------------------
  // Monitor, sampled at the falling edge
  // ----------------------------------------
  always @(negedge clk_i) begin
    if (rst_i) begin
      exp_aw_q.delete();
      exp_wlen_q.delete();
      grp_cnt_q.delete();
      grp_id_q.delete();
      exp_b_q.delete();
      beat_cnt    = 0;
      grp_rcv     = 0;
      grp_err     = 1'b0;
      outstanding = 0;
      errors_o    = 0;
    end else begin
      // Downstream B, grouped per upstream burst
      if (mst_b_valid_i && mst_b_ready_i) begin
        if (grp_cnt_q.size() == 0) begin
          event_error("downstream B taken with no burst expecting it");
        end else begin
          grp_rcv++;
          grp_err = grp_err || (mst_b_i.resp == axi_chan_pkg::RESP_SLVERR);
          if (grp_rcv == grp_cnt_q[0]) begin
            exp_b.id   = grp_id_q.pop_front();
            exp_b.resp = grp_err ? axi_chan_pkg::RESP_SLVERR : axi_chan_pkg::RESP_OKAY;
            exp_b_q.push_back(exp_b);
            void'(grp_cnt_q.pop_front());
            grp_rcv = 0;
            grp_err = 1'b0;
          end
        end
      end
      // Upstream B against the merged expectation
      if (slv_b_valid_i && slv_b_ready_i) begin
        if (exp_b_q.size() == 0) begin
          event_error("upstream B before all its sub-burst responses arrived");
        end else begin
          exp_b = exp_b_q.pop_front();
          if (slv_b_i != exp_b) value_error("B", 64'(exp_b), 64'(slv_b_i));
        end
        outstanding--;
      end
      // Upstream AW builds the expectation
      if (slv_aw_valid_i && slv_aw_ready_i) begin
        expand_burst(slv_aw_i, len_limit_i);
        outstanding++;
        if (outstanding > `BS_MAX_TXNS) begin
          event_error("more upstream bursts await B than the splitter may hold");
        end
      end
      if (mst_aw_valid_i && mst_aw_ready_i) begin
        if (exp_aw_q.size() == 0) begin
          event_error("downstream AW with no sub-burst expected");
        end else begin
          exp_sub = exp_aw_q.pop_front();
          if (mst_aw_i != exp_sub) value_error("AW", 64'(exp_sub), 64'(mst_aw_i));
        end
      end
      // W is a straight pass-through apart from last
      if ((slv_w_valid_i && slv_w_ready_i) != (mst_w_valid_i && mst_w_ready_i)) begin
        event_error("upstream and downstream W handshakes differ");
      end
      if (mst_w_valid_i && mst_w_ready_i) begin
        if (mst_w_i.data != slv_w_i.data) value_error("W data", slv_w_i.data, mst_w_i.data);
        if (mst_w_i.strb != slv_w_i.strb) value_error("W strb", slv_w_i.strb, mst_w_i.strb);
        if (exp_wlen_q.size() == 0) begin
          event_error("downstream W beat with no sub-burst expected");
        end else begin
          exp_last = beat_cnt == 32'(exp_wlen_q[0]);
          if (mst_w_i.last != exp_last) value_error("W last", exp_last, mst_w_i.last);
          if (exp_last) begin
            void'(exp_wlen_q.pop_front());
            beat_cnt = 0;
          end else begin
            beat_cnt++;
          end
        end
      end
    end
    drained_o = outstanding == 0 && exp_aw_q.size() == 0 && exp_wlen_q.size() == 0
                && exp_b_q.size() == 0 && grp_cnt_q.size() == 0;
  end

endmodule

`default_nettype wire

// ==== tb_burst_splitter.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "burst_split_params.svh"

module tb_burst_splitter;

  localparam int TIMEOUT_CYC = 2000;

  logic                   clk;
  logic                   rst;
  axi_chan_pkg::len_t     len_limit;
  axi_chan_pkg::aw_chan_t slv_aw, mst_aw;
  logic                   slv_aw_valid, slv_aw_ready, mst_aw_valid, mst_aw_ready;
  axi_chan_pkg::w_chan_t  slv_w, mst_w;
  logic                   slv_w_valid, slv_w_ready, mst_w_valid, mst_w_ready;
  axi_chan_pkg::b_chan_t  slv_b, mst_b;
  logic                   slv_b_valid, slv_b_ready, mst_b_valid, mst_b_ready;

  int          chk_errors;
  logic        drained;
  logic [31:0] lfsr_q = 32'hca62bf80;
  // Random readies on both sides when set
  logic        random_ready = 1'b0;
  // Upstream B held back until the FIFO is full when set
  logic        fill_fifo = 1'b0;
  // Every n-th downstream response is SLVERR or none when 0
  int          err_every = 0;
  int          timeouts = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          err_base;
  int          timeout_base;
  string       test_name = "reset";

  // Galois LFSR stepped once per bit taken
  function automatic logic lfsr_bit();
    logic b;
    b      = lfsr_q[0];
    lfsr_q = {1'b0, lfsr_q[31:1]} ^ (b ? 32'h80200003 : 32'h0);
    return b;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) v = {v[30:0], lfsr_bit()};
    return v;
  endfunction

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  burst_splitter_top dut (
    .clk_i (clk), .rst_i (rst), .len_limit_i (len_limit),
    .slv_aw_i (slv_aw), .slv_aw_valid_i (slv_aw_valid), .slv_aw_ready_o (slv_aw_ready),
    .slv_w_i (slv_w), .slv_w_valid_i (slv_w_valid), .slv_w_ready_o (slv_w_ready),
    .slv_b_o (slv_b), .slv_b_valid_o (slv_b_valid), .slv_b_ready_i (slv_b_ready),
    .mst_aw_o (mst_aw), .mst_aw_valid_o (mst_aw_valid), .mst_aw_ready_i (mst_aw_ready),
    .mst_w_o (mst_w), .mst_w_valid_o (mst_w_valid), .mst_w_ready_i (mst_w_ready),
    .mst_b_i (mst_b), .mst_b_valid_i (mst_b_valid), .mst_b_ready_o (mst_b_ready)
  );

  tb_checker chk (
    .clk_i (clk), .rst_i (rst), .len_limit_i (len_limit),
    .slv_aw_i (slv_aw), .slv_aw_valid_i (slv_aw_valid), .slv_aw_ready_i (slv_aw_ready),
    .slv_w_i (slv_w), .slv_w_valid_i (slv_w_valid), .slv_w_ready_i (slv_w_ready),
    .slv_b_i (slv_b), .slv_b_valid_i (slv_b_valid), .slv_b_ready_i (slv_b_ready),
    .mst_aw_i (mst_aw), .mst_aw_valid_i (mst_aw_valid), .mst_aw_ready_i (mst_aw_ready),
    .mst_w_i (mst_w), .mst_w_valid_i (mst_w_valid), .mst_w_ready_i (mst_w_ready),
    .mst_b_i (mst_b), .mst_b_valid_i (mst_b_valid), .mst_b_ready_i (mst_b_ready),
    .errors_o (chk_errors), .drained_o (drained)
  );

  // ----------------------------------------
  // Downstream slave model
  // ----------------------------------------
  initial begin
    logic              aw_hs, w_hs, b_hs;
    logic              hold_b;
    logic [2:0]        rnd;
    int unsigned       aw_seen, w_done, b_sent;
    axi_chan_pkg::id_t sub_id_q[$];
    mst_aw_ready = 1'b0;
    mst_w_ready  = 1'b0;
    mst_b        = '0;
    mst_b_valid  = 1'b0;
    slv_b_ready  = 1'b0;
    hold_b       = 1'b0;
    aw_seen      = 0;
    w_done       = 0;
    b_sent       = 0;
    forever begin
      // Handshakes of the coming edge are settled by now
      @(negedge clk);
      aw_hs = !rst && mst_aw_valid && mst_aw_ready;
      w_hs  = !rst && mst_w_valid && mst_w_ready && mst_w.last;
      b_hs  = !rst && mst_b_valid && mst_b_ready;
      if (aw_hs) sub_id_q.push_back(mst_aw.id);
      rnd    = random_ready ? {lfsr_bit(), lfsr_bit(), lfsr_bit()} : 3'b111;
      hold_b = fill_fifo;
      @(posedge clk);
      #1;
      if (aw_hs) aw_seen++;
      if (w_hs) w_done++;
      if (b_hs) begin
        mst_b_valid = 1'b0;
        b_sent++;
      end
      mst_aw_ready = rnd[0];
      mst_w_ready  = rnd[1];
      // Upstream B waits for a full FIFO so that further AW must stall
      slv_b_ready  = rnd[2] && (!hold_b || chk.outstanding >= `BS_MAX_TXNS);
      // Answer a sub-burst once its AW and all its W beats are in
      if (!mst_b_valid && b_sent < aw_seen && b_sent < w_done) begin
        mst_b.id    = sub_id_q.pop_front();
        mst_b.resp  = (err_every != 0 && b_sent % err_every == err_every - 1) ?
                      axi_chan_pkg::RESP_SLVERR : axi_chan_pkg::RESP_OKAY;
        mst_b_valid = 1'b1;
      end
    end
  end

  // ----------------------------------------
  // Upstream stimulus
  // ----------------------------------------
  task automatic note_timeout(input string what);
    $display("Timeout in test %s: no %s within %0d cycles", test_name, what, TIMEOUT_CYC);
    timeouts++;
  endtask

  // Hold valid until the DUT takes it
  task automatic await_accept(input bit is_w, input string what, output bit ok);
    int t;
    bit taken;
    t     = 0;
    taken = 1'b0;
    while (!taken && t < TIMEOUT_CYC) begin
      @(negedge clk);
      taken = is_w ? slv_w_ready : slv_aw_ready;
      @(posedge clk);
      #1;
      t++;
    end
    ok = taken;
    if (!taken) note_timeout(what);
  endtask

  task automatic send_burst(input axi_chan_pkg::id_t id, input axi_chan_pkg::addr_t addr,
                            input axi_chan_pkg::len_t len, input axi_chan_pkg::size_t size);
    bit ok;
    slv_aw.id    = id;
    slv_aw.addr  = addr;
    slv_aw.len   = len;
    slv_aw.size  = size;
    slv_aw_valid = 1'b1;
    await_accept(1'b0, "upstream AW ready", ok);
    slv_aw_valid = 1'b0;
    if (!ok) return;
    // Beats go back to back with data tagged by ID and beat
    for (int i = 0; i <= int'(len); i++) begin
      slv_w.data  = addr ^ {id, 20'h0, 8'(i)};
      slv_w.strb  = axi_chan_pkg::strb_t'(4'hf ^ 4'(i));
      slv_w.last  = i == int'(len);
      slv_w_valid = 1'b1;
      await_accept(1'b1, "upstream W ready", ok);
      slv_w_valid = 1'b0;
      if (!ok) return;
    end
  endtask

  // Limit only changes with nothing outstanding
  task automatic begin_test(input string name, input axi_chan_pkg::len_t limit, input int errs);
    test_name     = name;
    chk.test_name = name;
    len_limit     = limit;
    err_every     = errs;
    err_base      = chk_errors;
    timeout_base  = timeouts;
    tests_run++;
  endtask

  task automatic end_test();
    int t;
    int n;
    t = 0;
    while (!drained && t < TIMEOUT_CYC) begin
      @(posedge clk);
      #1;
      t++;
    end
    if (!drained) note_timeout("drain of all outstanding bursts");
    n = chk_errors - err_base;
    if (n != 0 || timeouts != timeout_base) tests_failed++;
    $display("test %-12s %s, %0d check errors", test_name,
             (n == 0 && timeouts == timeout_base) ? "ok" : "failed", n);
  endtask

  initial begin
    rst          = 1'b1;
    len_limit    = '0;
    slv_aw       = '0;
    slv_aw_valid = 1'b0;
    slv_w        = '0;
    slv_w_valid  = 1'b0;
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;

    begin_test("passthrough", 8'd7, 0);
    send_burst(4'h1, 32'h0000_1000, 8'd0, 3'd2);
    send_burst(4'h2, 32'h0000_2000, 8'd3, 3'd2);
    send_burst(4'h3, 32'h0000_3001, 8'd7, 3'd0);
    end_test();

    // Exact multiple, remainder, size 0 and 2
    begin_test("split", 8'd3, 0);
    send_burst(4'h4, 32'h0001_0000, 8'd15, 3'd2);
    send_burst(4'h5, 32'h0001_0103, 8'd10, 3'd0);
    send_burst(4'h6, 32'h0001_2000, 8'd13, 3'd2);
    end_test();

    begin_test("resp_merge", 8'd1, 3);
    for (int i = 0; i < 6; i++) send_burst(4'(i), 32'h0002_0000 + 32'(i) * 32'h40, 8'd5, 3'd2);
    end_test();

    begin_test("limit_zero", 8'd0, 4);
    for (int i = 0; i < 5; i++) send_burst(4'(i + 8), 32'h0003_0000 + 32'(i) * 32'h100,
                                           8'(i), 3'd1);
    end_test();

    // Back-pressure everywhere and the FIFO kept full
    begin_test("random", 8'(rand_bits(3)), 5);
    random_ready = 1'b1;
    fill_fifo    = 1'b1;
    for (int i = 0; i < 32; i++) send_burst(4'(rand_bits(4)), rand_bits(32), 8'(rand_bits(6)),
                                            3'(rand_bits(2) % 3));
    fill_fifo = 1'b0;
    end_test();
    random_ready = 1'b0;

    $display("tests run %0d, tests failed %0d, check errors %0d, timeouts %0d",
             tests_run, tests_failed, chk_errors, timeouts);
    if (chk_errors == 0 && timeouts == 0 && tests_failed == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+.
axi_chan_pkg.sv
split_ctrl_pkg.sv
aw_splitter.sv
w_last_gen.sv
b_merger.sv
burst_splitter_top.sv
tb_checker.sv
tb_burst_splitter.sv

// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := tb_burst_splitter
FLIST    := tb.f
PASS_MSG := *** TEST PASSED ***

.PHONY: sim clean

# Exit status follows the search for the pass line
sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	./obj_dir/V$(TOP) | awk '{ print } index($$0, "$(PASS_MSG)") { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir
